/* files.f */
+incdir+.
l15_pkg.sv
core_mem_pkg.sv
fetch_unit.sv
fetch_buffer.sv
data_port.sv
l15_arbiter.sv
core_mem_top.sv
tb_clock.sv
l15_model.sv
core_mem_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the core memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module core_mem_tb -f files.f -o core_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/core_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation reported failure"
	exit $status
fi

exit 0

/* core_mem_tb.sv */
`timescale 1ns/1ps
`include "l15_config.svh"

module core_mem_tb;
	import l15_pkg::*;
	import core_mem_pkg::*;

	localparam logic [`L15_ADDR_W-1:0] FILL_PATTERN = 32'h5a3c_96e1;
	localparam int ACK_MAX  = 3;
	localparam int RESP_MAX = 4;
	localparam int N_ITEMS  = 64;	// Instructions drained
	localparam int N_DATA   = 10;	// Loads and stores
	localparam int STALL    = 60;	// Extra cycles with the drain held off
	// Ack wait plus response wait plus arbitration per request
	localparam int WORST = ACK_MAX + RESP_MAX + 6;
	localparam int LIMIT = (N_ITEMS + N_DATA) * WORST + STALL + `TIMEOUT_MARGIN;
	localparam logic [`L15_ADDR_W-1:0] HOT_ADDR = `FETCH_RESET_PC + 32'd160;	// Item 40

	logic                   clk, nrst;
	logic                   instr_val, instr_rdy;
	fetch_item_t            instr;
	logic                   dreq_val, dreq_rdy, dresp_val;
	data_req_t              dreq;
	logic [`INSTR_W-1:0]    dresp_data;
	logic                   l15_val, l15_header_ack, l15_resp_val, l15_resp_ack;
	l15_req_t               l15_req;
	l15_resp_t              l15_resp;

	logic [`INSTR_W-1:0]    shadow [logic [`L15_ADDR_W-1:0]];	// Words the test stored
	logic [`L15_ADDR_W-1:0] exp_pc = `FETCH_RESET_PC;
	int                     drained = 0;
	int                     cycles = 0;
	int                     stall_fills = 0;	// Fills sent while drain held
	logic                   stall_win = 1'b0;
	logic                   outstanding = 1'b0;	// Request sent and no response yet
	logic                   data_open = 1'b0;	// Data op on the port and dresp not seen

	tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(10)) clock_gen (.clk(clk), .nrst(nrst));

	core_mem_top core_mem_top_inst (.*);

	l15_model #(.FILL_PATTERN(FILL_PATTERN), .ACK_MAX(ACK_MAX), .RESP_MAX(RESP_MAX))
		l15_mem (.*);

	// Expected memory word from the fill rule and the stores so far
	function automatic logic [`INSTR_W-1:0] expected_word(input logic [`L15_ADDR_W-1:0] a);
		return shadow.exists(a) ? shadow[a] : a ^ FILL_PATTERN;
	endfunction

	task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
			$display("sim failed");
			$fatal(1, "Wrong value on %s", what);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// One load or store from idle to dresp_val
	task automatic run_data_op(input logic st, input logic [`L15_ADDR_W-1:0] addr,
			input logic [`INSTR_W-1:0] wdata);
		logic [`INSTR_W-1:0] want;
		want = st ? '0 : expected_word(addr);
		while (!dreq_rdy)
			next_cycle();
		dreq_val   = 1'b1;
		dreq.store = st;
		dreq.addr  = addr;
		dreq.wdata = wdata;
		next_cycle();
		dreq_val = 1'b0;
		if (st)
			shadow[addr] = wdata;
		while (!dresp_val)
			next_cycle();
		check_val(st ? "store ack data" : "load data", dresp_data, want);
		next_cycle();
	endtask

	// Port monitor sampled mid-cycle where everything is settled
	always @(negedge clk)
	begin
		if (nrst)
		begin
			if (instr_val && instr_rdy)
			begin
				check_val("drained pc", instr.pc, exp_pc);
				check_val("drained instr", instr.instr, expected_word(exp_pc));
				exp_pc  = exp_pc + 4;
				drained = drained + 1;
			end
			if (l15_val)
			begin
				// Port stays quiet while a request waits for its answer
				check_val("request with one outstanding", outstanding, 1'b0);
				check_val("request size", l15_req.size, l15_size_4b);
				if (l15_req.rqtype != l15_rq_ifill)
					data_open = 1'b1;
			end
			if (l15_val && l15_header_ack)
			begin
				outstanding = 1'b1;
				if (l15_req.rqtype == l15_rq_ifill)
				begin
					check_val("ifill during data op", data_open, 1'b0);
					if (stall_win)
						stall_fills = stall_fills + 1;
				end
			end
			if (l15_resp_val && l15_resp_ack)
				outstanding = 1'b0;
			if (dresp_val)
				data_open = 1'b0;	// Fills allowed again
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > LIMIT)
		begin
			$display("sim failed");
			$fatal(1, "Timeout after %0d cycles, the DUT stopped making progress", cycles);
		end
	end

	initial
	begin
		logic [`L15_ADDR_W-1:0] addr;
		logic [`INSTR_W-1:0]    wval;
		instr_rdy = 1'b0;
		dreq_val  = 1'b0;
		dreq      = '0;
		void'($urandom(88375));
		// Quiet outputs through reset and one cycle past it
		do
		begin
			@(negedge clk);
			check_val("l15_val in reset", l15_val, 1'b0);
			check_val("l15_resp_ack in reset", l15_resp_ack, 1'b0);
			check_val("instr_val in reset", instr_val, 1'b0);
			check_val("dresp_val in reset", dresp_val, 1'b0);
			check_val("dreq_rdy in reset", dreq_rdy, 1'b1);
		end
		while (!nrst);
		next_cycle();
		instr_rdy = 1'b1;
		while (drained < 8)
			next_cycle();
		// Drain held off while the data ops run
		instr_rdy = 1'b0;
		stall_win = 1'b1;
		run_data_op(1'b0, 32'h0000_4000 + ($urandom_range(255) << 2), '0);
		run_data_op(1'b0, 32'h0000_2004, '0);	// Upper half of the beat
		run_data_op(1'b1, HOT_ADDR, $urandom);
		run_data_op(1'b0, HOT_ADDR, '0);
		for (int i = 0; i < 3; i++)
		begin
			addr = 32'h0000_8000 + ($urandom_range(1023) << 2);
			wval = $urandom;
			run_data_op(1'b1, addr, wval);
			run_data_op(1'b0, addr, '0);
		end
		repeat (STALL) next_cycle();
		check_val("fills while drain held", stall_fills <= `FETCH_BUF_DEPTH + 1, 1'b1);
		stall_win = 1'b0;
		// Random drain that passes the stored fetch address
		while (drained < N_ITEMS)
		begin
			instr_rdy = ($urandom_range(3) != 0);
			next_cycle();
		end
		instr_rdy = 1'b0;
		$display("sim passed");
		$finish;
	end

endmodule

/* l15_model.sv */
`timescale 1ns/1ps
`include "l15_config.svh"

module l15_model #(
	parameter logic [`L15_ADDR_W-1:0] FILL_PATTERN = 32'h5a3c_96e1,
	parameter int                     ACK_MAX      = 3,
	parameter int                     RESP_MAX     = 4
) (
	input  logic               clk,
	input  logic               nrst,
	input  logic               l15_val,
	input  l15_pkg::l15_req_t  l15_req,
	output logic               l15_header_ack,
	output logic               l15_resp_val,
	output l15_pkg::l15_resp_t l15_resp,
	input  logic               l15_resp_ack
);
	import l15_pkg::*;

	logic [`INSTR_W-1:0] mem [logic [`L15_ADDR_W-1:0]];	// Only words written by stores
	l15_req_t            cur;
	logic                taken;

	// Unwritten words follow the address
	function automatic logic [`INSTR_W-1:0] read_word(input logic [`L15_ADDR_W-1:0] a);
		return mem.exists(a) ? mem[a] : a ^ FILL_PATTERN;
	endfunction

	task automatic serve(input l15_req_t r);
		logic [`L15_ADDR_W-1:0] base;
		logic                   acked;
		base = {r.address[`L15_ADDR_W-1:3], 3'b000};	// 64-bit beat
		if (r.rqtype == l15_rq_store)
			mem[{r.address[`L15_ADDR_W-1:2], 2'b00}] = r.data[`INSTR_W-1:0];
		repeat ($urandom_range(RESP_MAX))
		begin
			@(posedge clk);
			#1;
		end
		l15_resp.data = {read_word(base + `L15_ADDR_W'(4)), read_word(base)};
		case (r.rqtype)
			l15_rq_ifill:
				l15_resp.returntype = l15_ret_ifill;
			l15_rq_store:
			begin
				l15_resp.returntype = l15_ret_st_ack;
				l15_resp.data       = '0;	// Ack only
			end
			default:
				l15_resp.returntype = l15_ret_load;
		endcase
		l15_resp_val = 1'b1;
		acked        = 1'b0;
		while (!acked)
		begin
			@(negedge clk);
			acked = l15_resp_ack;	// Transfer on the coming edge
			@(posedge clk);
		end
		#1 l15_resp_val = 1'b0;
		l15_resp = '0;
	endtask

	initial
	begin
		l15_header_ack = 1'b0;
		l15_resp_val   = 1'b0;
		l15_resp       = '0;
		forever
		begin
			@(negedge clk);
			if (nrst && l15_val)
			begin
				repeat ($urandom_range(ACK_MAX)) @(posedge clk);
				@(posedge clk);
				#1 l15_header_ack = 1'b1;
				@(negedge clk);
				taken = l15_val;	// Arbiter may have pulled a fill meanwhile
				cur   = l15_req;
				@(posedge clk);
				#1 l15_header_ack = 1'b0;
				if (taken)
					serve(cur);
			end
		end
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 nrst = 1'b1;	// Released just after an edge
	end

endmodule

/* core_mem_top.sv */
`timescale 1ns/1ps
`include "l15_config.svh"

module core_mem_top (
	input  logic                      clk,
	input  logic                      nrst,
	output logic                      instr_val,
	output core_mem_pkg::fetch_item_t instr,
	input  logic                      instr_rdy,
	input  logic                      dreq_val,
	input  core_mem_pkg::data_req_t   dreq,
	output logic                      dreq_rdy,
	output logic                      dresp_val,
	output logic [`INSTR_W-1:0]       dresp_data,
	output logic                      l15_val,
	output l15_pkg::l15_req_t         l15_req,
	input  logic                      l15_header_ack,
	input  logic                      l15_resp_val,
	input  l15_pkg::l15_resp_t        l15_resp,
	output logic                      l15_resp_ack
);
	import l15_pkg::*;
	import core_mem_pkg::*;

	// Fetch side of the arbiter
	logic        f_req_val, f_req_ack, f_resp_val, f_resp_ack;
	l15_req_t    f_req;
	l15_resp_t   f_resp;
	// Data side of the arbiter
	logic        d_req_val, d_req_ack, d_resp_val, d_resp_ack;
	l15_req_t    d_req;
	l15_resp_t   d_resp;
	// Fetch to buffer
	logic        push, buf_free;
	fetch_item_t push_item;

	fetch_unit u_fetch (
		.clk(clk), .nrst(nrst),
		.req_val(f_req_val), .req(f_req), .req_ack(f_req_ack),
		.resp_val(f_resp_val), .resp(f_resp), .resp_ack(f_resp_ack),
		.push(push), .push_item(push_item), .buf_free(buf_free)
	);

	fetch_buffer u_buf (
		.clk(clk), .nrst(nrst),
		.push(push), .push_item(push_item), .buf_free(buf_free),
		.instr_val(instr_val), .instr(instr), .instr_rdy(instr_rdy)
	);

	data_port u_data (
		.clk(clk), .nrst(nrst),
		.dreq_val(dreq_val), .dreq(dreq), .dreq_rdy(dreq_rdy),
		.dresp_val(dresp_val), .dresp_data(dresp_data),
		.req_val(d_req_val), .req(d_req), .req_ack(d_req_ack),
		.resp_val(d_resp_val), .resp(d_resp), .resp_ack(d_resp_ack)
	);

	l15_arbiter u_arb (
		.clk(clk), .nrst(nrst),
		.fetch_req_val(f_req_val), .fetch_req(f_req), .fetch_req_ack(f_req_ack),
		.fetch_resp_val(f_resp_val), .fetch_resp(f_resp), .fetch_resp_ack(f_resp_ack),
		.data_req_val(d_req_val), .data_req(d_req), .data_req_ack(d_req_ack),
		.data_resp_val(d_resp_val), .data_resp(d_resp), .data_resp_ack(d_resp_ack),
		.l15_val(l15_val), .l15_req(l15_req), .l15_header_ack(l15_header_ack),
		.l15_resp_val(l15_resp_val), .l15_resp(l15_resp), .l15_resp_ack(l15_resp_ack)
	);

endmodule

/* l15_arbiter.sv */
`timescale 1ns/1ps

module l15_arbiter (
	input  logic               clk,
	input  logic               nrst,
	input  logic               fetch_req_val,
	input  l15_pkg::l15_req_t  fetch_req,
	output logic               fetch_req_ack,
	output logic               fetch_resp_val,
	output l15_pkg::l15_resp_t fetch_resp,
	input  logic               fetch_resp_ack,
	input  logic               data_req_val,
	input  l15_pkg::l15_req_t  data_req,
	output logic               data_req_ack,
	output logic               data_resp_val,
	output l15_pkg::l15_resp_t data_resp,
	input  logic               data_resp_ack,
	output logic               l15_val,
	output l15_pkg::l15_req_t  l15_req,
	input  logic               l15_header_ack,
	input  logic               l15_resp_val,
	input  l15_pkg::l15_resp_t l15_resp,
	output logic               l15_resp_ack
);
	import core_mem_pkg::*;

	arb_state_t state;
	logic       fetch_out;	// Fill sent and not yet answered
	logic       fetch_resp_fire;
	logic       data_resp_fire;

	assign fetch_resp_fire = fetch_resp_val && fetch_resp_ack;
	assign data_resp_fire  = data_resp_val && data_resp_ack;

	// Payload fans out, valids pick the owner
	assign fetch_resp = l15_resp;
	assign data_resp  = l15_resp;

	always_comb
	begin
		l15_val        = 1'b0;
		l15_req        = fetch_req;
		fetch_req_ack  = 1'b0;
		data_req_ack   = 1'b0;
		fetch_resp_val = 1'b0;
		data_resp_val  = 1'b0;
		l15_resp_ack   = 1'b0;
		case (state)
			arb_fetch:
			begin
				l15_val        = fetch_req_val;
				fetch_req_ack  = l15_header_ack;
				fetch_resp_val = l15_resp_val;
				l15_resp_ack   = fetch_resp_ack;
			end
			arb_wait:
			begin
				// Neither side granted, last fill may still return
				fetch_resp_val = l15_resp_val;
				l15_resp_ack   = fetch_resp_ack;
			end
			arb_data:
			begin
				l15_val       = data_req_val;
				l15_req       = data_req;
				data_req_ack  = l15_header_ack;
				data_resp_val = l15_resp_val;
				l15_resp_ack  = data_resp_ack;
			end
			default:
				l15_val = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state     <= arb_fetch;
			fetch_out <= 1'b0;
		end
		else
		begin
			if (fetch_req_val && fetch_req_ack)
				fetch_out <= 1'b1;
			else if (fetch_resp_fire)
				fetch_out <= 1'b0;
			case (state)
				arb_fetch:
					if (data_req_val)
						state <= arb_wait;	// Stop granting fills
				arb_wait:
					if (!fetch_out || fetch_resp_fire)
						state <= arb_data;
				arb_data:
					if (data_resp_fire)
						state <= arb_fetch;	// Op done, hand back
				default:
					state <= arb_fetch;
			endcase
		end
	end

	// In fetch ownership any response must belong to a fill we sent
	a_resp_owner: assert property (@(posedge clk) disable iff (!nrst)
		l15_resp_val && state == arb_fetch |-> fetch_out);

endmodule

/* data_port.sv */
`timescale 1ns/1ps
`include "l15_config.svh"

module data_port (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    dreq_val,
	input  core_mem_pkg::data_req_t dreq,
	output logic                    dreq_rdy,
	output logic                    dresp_val,
	output logic [`INSTR_W-1:0]     dresp_data,
	output logic                    req_val,
	output l15_pkg::l15_req_t       req,
	input  logic                    req_ack,
	input  logic                    resp_val,
	input  l15_pkg::l15_resp_t      resp,
	output logic                    resp_ack
);
	import l15_pkg::*;
	import core_mem_pkg::*;

	data_req_t           hold;	// Captured op
	logic                busy;	// Op in progress
	logic                resp_fire;
	logic [`INSTR_W-1:0] ld_word;

	assign dreq_rdy  = !busy;
	assign resp_ack  = resp_val && busy && !req_val;	// Only once the request left
	assign resp_fire = resp_val && resp_ack;

	always_comb
	begin
		req.rqtype  = hold.store ? l15_rq_store : l15_rq_load;
		req.size    = l15_size_4b;
		req.address = hold.addr;
		req.data    = {(`L15_DATA_W / `INSTR_W){hold.wdata}};	// Word copied to each half
	end

	assign ld_word = hold.addr[2] ? resp.data[`L15_DATA_W-1 -: `INSTR_W] : resp.data[`INSTR_W-1:0];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			busy      <= 1'b0;
			req_val   <= 1'b0;
			dresp_val <= 1'b0;
		end
		else
		begin
			dresp_val <= resp_fire;	// One-cycle completion pulse
			if (dreq_val && dreq_rdy)
			begin
				busy    <= 1'b1;
				req_val <= 1'b1;
			end
			if (req_val && req_ack)
				req_val <= 1'b0;
			if (resp_fire)
				busy <= 1'b0;	// Back to idle
		end
	end

	always_ff @(posedge clk)
	begin
		if (dreq_val && dreq_rdy)
			hold <= dreq;
		if (resp_fire)
			dresp_data <= hold.store ? '0 : ld_word;	// Store ack carries zero
	end

endmodule

/* fetch_buffer.sv */
`timescale 1ns/1ps
`include "l15_config.svh"

module fetch_buffer (
	input  logic                      clk,
	input  logic                      nrst,
	input  logic                      push,
	input  core_mem_pkg::fetch_item_t push_item,
	output logic                      buf_free,
	output logic                      instr_val,
	output core_mem_pkg::fetch_item_t instr,
	input  logic                      instr_rdy
);
	import core_mem_pkg::*;

	localparam int DEPTH = `FETCH_BUF_DEPTH;
	localparam int PW    = $clog2(DEPTH);
	localparam int CW    = $clog2(DEPTH + 1);

	fetch_item_t   mem [DEPTH];	// Item storage
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;	// Items held
	logic          pop;

	assign pop       = instr_val && instr_rdy;
	assign instr_val = (count != '0);
	assign instr     = mem[rd_ptr];	// Head of queue

	// An item pushed this cycle already takes a slot
	assign buf_free = push ? (count < CW'(DEPTH - 1)) : (count < CW'(DEPTH));

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(push) - CW'(pop);	// Net change
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_item;
	end

	// Fetch must never send an item the buffer cannot hold
	a_no_overflow: assert property (@(posedge clk) disable iff (!nrst)
		push |-> count < CW'(DEPTH));

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "l15_config.svh"

module fetch_unit (
	input  logic                      clk,
	input  logic                      nrst,
	output logic                      req_val,
	output l15_pkg::l15_req_t         req,
	input  logic                      req_ack,
	input  logic                      resp_val,
	input  l15_pkg::l15_resp_t        resp,
	output logic                      resp_ack,
	output logic                      push,
	output core_mem_pkg::fetch_item_t push_item,
	input  logic                      buf_free
);
	import l15_pkg::*;

	logic [`L15_ADDR_W-1:0] fetch_pc;	// Next fill address
	logic [`L15_ADDR_W-1:0] item_pc;	// Address of the fill in flight
	logic                   out_pend;	// Fill taken and data not back yet
	logic                   req_fire;
	logic                   resp_fire;
	logic [`INSTR_W-1:0]    word;

	assign req_fire  = req_val && req_ack;
	assign resp_fire = resp_val && resp_ack;
	assign resp_ack  = resp_val && out_pend;	// Only our own fill

	// Sequential ifill of one word each
	always_comb
	begin
		req.rqtype  = l15_rq_ifill;
		req.size    = l15_size_4b;
		req.address = fetch_pc;
		req.data    = '0;
	end

	// Bit 2 picks the half of the 64-bit beat
	assign word = item_pc[2] ? resp.data[`L15_DATA_W-1 -: `INSTR_W] : resp.data[`INSTR_W-1:0];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			req_val  <= 1'b0;
			out_pend <= 1'b0;
			push     <= 1'b0;
			fetch_pc <= `FETCH_RESET_PC;
		end
		else
		begin
			push <= resp_fire;	// Item lands one cycle after data
			if (req_fire)
			begin
				req_val  <= 1'b0;
				out_pend <= 1'b1;
				fetch_pc <= fetch_pc + `L15_ADDR_W'(4);
			end
			else if (!req_val && !out_pend && buf_free)
				req_val <= 1'b1;	// Room reserved for this fill
			if (resp_fire)
				out_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_fire)
			item_pc <= fetch_pc;
		if (resp_fire)
		begin
			push_item.pc    <= item_pc;
			push_item.instr <= word;
		end
	end

	// A fill response only shows up while our fill is out
	a_resp_pending: assert property (@(posedge clk) disable iff (!nrst)
		resp_val |-> out_pend);

endmodule

/* core_mem_pkg.sv */
`include "l15_config.svh"

package core_mem_pkg;

	// One fetched instruction with its address
	typedef struct packed {
		logic [`L15_ADDR_W-1:0] pc;
		logic [`INSTR_W-1:0]    instr;
	} fetch_item_t;

	// External load or store
	typedef struct packed {
		logic                   store;	// Low for a load
		logic [`L15_ADDR_W-1:0] addr;
		logic [`INSTR_W-1:0]    wdata;	// Ignored on loads
	} data_req_t;

	// Owner of the shared L1.5 port
	typedef enum logic [1:0] {
		arb_fetch = 2'd0,	// Fetch owns the port
		arb_wait  = 2'd1,	// Draining the last fill
		arb_data  = 2'd2	// Data port owns the port
	} arb_state_t;

endpackage

/* l15_pkg.sv */
`include "l15_config.svh"

package l15_pkg;

	// Request codes on the L1.5 port
	typedef enum logic [4:0] {
		l15_rq_load  = 5'b00000,
		l15_rq_store = 5'b00001,
		l15_rq_ifill = 5'b10000	// Instruction miss
	} l15_rqtype_t;

	// Return codes
	typedef enum logic [3:0] {
		l15_ret_load   = 4'b0000,
		l15_ret_ifill  = 4'b0001,
		l15_ret_st_ack = 4'b0100
	} l15_rettype_t;

	localparam logic [2:0] l15_size_4b = 3'b010;	// One 32-bit word

	typedef struct packed {
		l15_rqtype_t            rqtype;
		logic [2:0]             size;
		logic [`L15_ADDR_W-1:0] address;
		logic [`L15_DATA_W-1:0] data;	// Store data, word in both halves
	} l15_req_t;

	typedef struct packed {
		l15_rettype_t           returntype;
		logic [`L15_DATA_W-1:0] data;
	} l15_resp_t;

endpackage

/* l15_config.svh */
`ifndef L15_CONFIG_SVH
`define L15_CONFIG_SVH

// L1.5 port widths
`define L15_ADDR_W 32
`define L15_DATA_W 64	// One response beat

// Instruction word and load/store word
`define INSTR_W 32

// Entries in the fetch buffer
`define FETCH_BUF_DEPTH 4

// First fill address after reset
`define FETCH_RESET_PC 32'h0000_0100

// Extra cycles on top of the worst-case run time
`define TIMEOUT_MARGIN 2000

`endif
